// ==== mem_subsys.f ====
+incdir+tests
source/mem_pkg.sv
source/lsu.sv
source/ifetch.sv
source/axi_read_arbiter.sv
source/axi_sram.sv
source/mem_subsys.sv
tests/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_subsys.f \
  --top-module tb_mem_subsys -o tb_mem_subsys
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_mem_subsys)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== tests/tb_tasks.svh ====
task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
  checks++;
  assert (got === exp) else begin
    errors++;
    test_errs++;
    $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic end_test(input string name);
  if (test_errs == 0) $display("%s: all checks ok", name);
  else $display("%s: %0d errors", name, test_errs);
  test_errs = 0;
endtask

task automatic report_timeout(input string what);
  $display("timeout at %0t: %s", $time, what);
  timed_out = 1'b1;
  forever @(negedge clk);
endtask

// one core-side operation starting on a falling edge
task automatic lsu_op(input logic rd, input logic wr, input logic [31:0] addr,
                      input logic [31:0] data, input logic [7:0] mask, input load_op_e op,
                      output logic [31:0] result);
  int n;
  ren = rd;
  wen = wr;
  raddr = addr;
  waddr = addr;
  wdata = data;
  wmask = mask;
  load_ctl = op;
  inst_rvalid = 1'b1;
  @(negedge clk);
  inst_rvalid = 1'b0;
  n = 0;
  while (!lsu_finish && n < timeout_cycles) begin
    @(negedge clk);
    n++;
  end
  if (!lsu_finish) report_timeout("load/store unit never raised lsu_finish");
  result = rdata;
endtask

task automatic store(input logic [31:0] addr, input logic [31:0] data, input logic [7:0] mask);
  logic [31:0] discard;
  lsu_op(1'b0, 1'b1, addr, data, mask, lw, discard);
  apply_store(addr, data, mask);
endtask

task automatic load_check(input logic [31:0] addr, input load_op_e op);
  logic [31:0] got;
  lsu_op(1'b1, 1'b0, addr, 32'h0, 8'h00, op, got);
  check_val(got, expect_load(addr, op), $sformatf("%s at %h", op.name(), addr));
endtask

task automatic fetch_check(input logic [31:0] pc);
  int n;
  fetch_req = 1'b1;
  fetch_pc = pc;
  @(negedge clk);
  fetch_req = 1'b0;
  n = 0;
  while (!inst_valid && n < timeout_cycles) begin
    @(negedge clk);
    n++;
  end
  if (!inst_valid) report_timeout("fetch unit never raised inst_valid");
  check_val(inst, expect_fetch(pc), $sformatf("fetch at %h", pc));
endtask

task automatic fill_window();
  logic [31:0] addr;
  for (int i = 0; i < win_bytes / 4; i++) begin
    addr = sram_lo + 32'(i * 4);
    store(addr, (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]}, 8'h0f);
  end
endtask

task automatic aligned_word_test();
  logic [31:0] addr;
  logic [31:0] data;
  logic [31:0] got;
  for (int i = 0; i < 4; i++) begin
    addr = sram_lo + 32'h80 + 32'(i * 8);
    data = $urandom;
    store(addr, data, 8'h0f);
    lsu_op(1'b1, 1'b0, addr, 32'h0, 8'h00, lw, got);
    check_val(got, data, "lw after aligned store");
    check_val(got, expect_load(addr, lw), "lw against model after aligned store");
  end
  end_test("aligned word");
endtask

task automatic byte_half_test();
  load_op_e ops [5];
  ops = '{lb, lh, lw, lbu, lhu};
  // sign bits set and clear in both words
  store(sram_lo + 32'h10, 32'h80ff_7f01, 8'h0f);
  store(sram_lo + 32'h14, 32'hfe81_00c3, 8'h0f);
  for (int off = 0; off < 8; off++) begin
    for (int k = 0; k < 5; k++) begin
      load_check(sram_lo + 32'h10 + 32'(off), ops[k]);
    end
  end
  end_test("byte and half loads");
endtask

task automatic boundary_test();
  logic [31:0] addr;
  for (int off = 5; off < 8; off++) begin
    addr = sram_lo + 32'h20 + 32'(off);
    store(addr, $urandom, 8'h0f);
    load_check(addr, lw);
    load_check(addr - 1, lbu);
    load_check(addr + 4, lbu);
    addr = sram_lo + 32'h30 + 32'(off);
    store(addr, $urandom, 8'h03);
    load_check(addr, lh);
    load_check(addr - 1, lbu);
    load_check(addr + 2, lbu);
  end
  for (int i = 0; i < 8; i++) begin
    load_check(sram_lo + 32'h20 + 32'(i * 4), lw);
  end
  end_test("boundary crossing");
endtask

task automatic device_test();
  logic [31:0] got;
  // aliases onto sram bytes 0x40 to 0x43
  store(32'h2000_0045, 32'hc0de_5a17, 8'h0f);
  lsu_op(1'b1, 1'b0, sram_lo + 32'h40, 32'h0, 8'h00, lw, got);
  check_val(got, 32'hc0de_5a17, "sram alias lw after device store");
  load_check(sram_lo + 32'h44, lw);
  store(32'h2000_004b, 32'h1234_5678, 8'h06);
  load_check(sram_lo + 32'h48, lw);
  load_check(sram_lo + 32'h4c, lw);
  load_check(32'h2000_0046, lw);
  load_check(32'h2000_004a, lbu);
  end_test("device region");
endtask

task automatic overlap_test();
  logic [31:0] pcs [12];
  logic [31:0] lds [12];
  for (int i = 0; i < 12; i++) begin
    pcs[i] = sram_lo + 32'(($urandom % 64) * 4);
    lds[i] = sram_lo + 32'($urandom % 252);
  end
  fork
    begin
      for (int i = 0; i < 12; i++) fetch_check(pcs[i]);
    end
    begin
      for (int i = 0; i < 12; i++) load_check(lds[i], lw);
    end
  join
  end_test("fetch and load overlap");
endtask

task automatic random_mix_test();
  load_op_e    ops [5];
  logic [7:0]  masks [5];
  logic [31:0] slot;
  logic [31:0] off;
  int          kind;
  ops = '{lb, lh, lw, lbu, lhu};
  masks = '{8'h01, 8'h03, 8'h0f, 8'h01, 8'h03};
  for (int i = 0; i < 60; i++) begin
    slot = $urandom % 30;
    off = $urandom % 8;
    kind = int'($urandom % 5);
    if ($urandom % 2 == 0) store(sram_lo + slot * 8 + off, $urandom, masks[kind]);
    else load_check(sram_lo + slot * 8 + off, ops[kind]);
  end
  // no ren and no wen finishes on the next cycle
  ren = 1'b0;
  wen = 1'b0;
  inst_rvalid = 1'b1;
  @(negedge clk);
  inst_rvalid = 1'b0;
  checks++;
  assert (lsu_finish) else begin
    errors++;
    test_errs++;
    $display("issue with neither ren nor wen gave no lsu_finish on the next cycle");
  end
  end_test("random mix");
endtask

// ==== tests/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;
  import mem_pkg::*;

  localparam logic [31:0] sram_lo = 32'h0f00_0000;
  localparam logic [31:0] sram_hi = 32'h0f00_2000;
  // 1024 beats of 8 bytes
  localparam int mem_bytes = 8192;
  // low part of the sram that the tests touch
  localparam int win_bytes = 256;
  localparam int timeout_cycles = 200;

  logic        clk;
  logic        rst;
  logic        inst_rvalid;
  logic        ren;
  logic        wen;
  logic [31:0] raddr;
  logic [31:0] waddr;
  logic [31:0] wdata;
  logic [7:0]  wmask;
  load_op_e    load_ctl;
  logic [31:0] rdata;
  logic        lsu_finish;
  logic        fetch_req;
  logic [31:0] fetch_pc;
  logic [31:0] inst;
  logic        inst_valid;

  // byte model of the memory, aliased like the real array
  logic [7:0]  model_mem [mem_bytes];
  int          checks;
  int          errors;
  int          test_errs;
  logic        timed_out;

  mem_subsys #(
    .sram_base(sram_lo),
    .sram_size(sram_hi - sram_lo),
    .mem_words(mem_bytes / 8)
  ) u_dut (
    .clk, .rst, .inst_rvalid, .ren, .wen, .raddr, .waddr, .wdata, .wmask, .load_ctl,
    .rdata, .lsu_finish, .fetch_req, .fetch_pc, .inst, .inst_valid
  );

  always #5 clk = ~clk;

  function automatic int mem_index(input logic [31:0] addr);
    return int'(addr % mem_bytes);
  endfunction

  function automatic logic in_sram(input logic [31:0] addr);
    return addr >= sram_lo && addr < sram_hi;
  endfunction

  // mask bit j writes byte j of the zero-extended word
  function automatic void apply_store(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [7:0] mask);
    logic [63:0] wide;
    logic [31:0] base;
    wide = {32'h0, data};
    // device stores land unshifted at the aligned beat
    base = in_sram(addr) ? addr : {addr[31:3], 3'b000};
    for (int j = 0; j < 8; j++) begin
      if (mask[j]) model_mem[mem_index(base + j)] = wide[j*8 +: 8];
    end
  endfunction

  function automatic logic [31:0] expect_load(input logic [31:0] addr, input load_op_e op);
    logic [31:0] start;
    logic [31:0] raw;
    int          nb;
    case (op)
      lb, lbu: nb = 1;
      lh, lhu: nb = 2;
      default: nb = 4;
    endcase
    // device loads take the low word of the aligned beat
    start = in_sram(addr) ? addr : {addr[31:3], 3'b000};
    raw = '0;
    for (int k = 0; k < nb; k++) begin
      raw[k*8 +: 8] = model_mem[mem_index(start + k)];
    end
    case (op)
      lb:      return {{24{raw[7]}}, raw[7:0]};
      lh:      return {{16{raw[15]}}, raw[15:0]};
      default: return raw;
    endcase
  endfunction

  function automatic logic [31:0] expect_fetch(input logic [31:0] pc);
    logic [31:0] word;
    for (int k = 0; k < 4; k++) begin
      word[k*8 +: 8] = model_mem[mem_index({pc[31:2], 2'b00} + k)];
    end
    return word;
  endfunction

  `include "tb_tasks.svh"

  initial begin
    wait (timed_out);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inst_rvalid = 1'b0;
    ren = 1'b0;
    wen = 1'b0;
    raddr = '0;
    waddr = '0;
    wdata = '0;
    wmask = '0;
    load_ctl = lw;
    fetch_req = 1'b0;
    fetch_pc = '0;
    checks = 0;
    errors = 0;
    test_errs = 0;
    timed_out = 1'b0;
    void'($urandom(47234));
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    fill_window();
    aligned_word_test();
    byte_half_test();
    boundary_test();
    device_test();
    overlap_test();
    random_mix_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys #(
  parameter logic [mem_pkg::addr_w-1:0] sram_base = mem_pkg::sram_base_def,
  parameter logic [mem_pkg::addr_w-1:0] sram_size = mem_pkg::sram_size_def,
  parameter int                         mem_words = mem_pkg::mem_words_def
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       inst_rvalid,
  input  logic                       ren,
  input  logic                       wen,
  input  logic [mem_pkg::addr_w-1:0] raddr,
  input  logic [mem_pkg::addr_w-1:0] waddr,
  input  logic [mem_pkg::data_w-1:0] wdata,
  input  logic [7:0]                 wmask,
  input  mem_pkg::load_op_e          load_ctl,
  output logic [mem_pkg::data_w-1:0] rdata,
  output logic                       lsu_finish,
  input  logic                       fetch_req,
  input  logic [mem_pkg::addr_w-1:0] fetch_pc,
  output logic [mem_pkg::data_w-1:0] inst,
  output logic                       inst_valid
);
  import mem_pkg::*;

  // fetch side, arbiter m0
  logic              f_ar_valid, f_ar_ready, f_r_valid, f_r_ready;
  logic [addr_w-1:0] f_ar_addr;
  logic [bus_w-1:0]  f_r_data;
  // load/store read side, arbiter m1
  logic              l_ar_valid, l_ar_ready, l_r_valid, l_r_ready;
  logic [addr_w-1:0] l_ar_addr;
  logic [bus_w-1:0]  l_r_data;
  resp_e             l_r_resp;
  // memory read port
  logic              s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
  logic [addr_w-1:0] s_ar_addr;
  logic [bus_w-1:0]  s_r_data;
  resp_e             s_r_resp;
  // write channels, lsu only
  logic              aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic [addr_w-1:0] aw_addr;
  logic [bus_w-1:0]  w_data;
  logic [strb_w-1:0] w_strb;
  resp_e             b_resp;

  lsu #(.sram_base(sram_base), .sram_size(sram_size)) u_lsu (
    .clk, .rst, .inst_rvalid, .ren, .wen, .raddr, .waddr, .wdata, .wmask, .load_ctl,
    .rdata, .lsu_finish,
    .ar_valid(l_ar_valid), .ar_ready(l_ar_ready), .ar_addr(l_ar_addr),
    .r_valid(l_r_valid), .r_ready(l_r_ready), .r_data(l_r_data), .r_resp(l_r_resp),
    .aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data, .w_strb,
    .b_valid, .b_ready, .b_resp
  );

  ifetch u_ifetch (
    .clk, .rst, .fetch_req, .fetch_pc, .inst, .inst_valid,
    .ar_valid(f_ar_valid), .ar_ready(f_ar_ready), .ar_addr(f_ar_addr),
    .r_valid(f_r_valid), .r_ready(f_r_ready), .r_data(f_r_data)
  );

  axi_read_arbiter u_arb (
    .clk, .rst,
    .m0_ar_valid(f_ar_valid), .m0_ar_ready(f_ar_ready), .m0_ar_addr(f_ar_addr),
    .m0_r_valid(f_r_valid), .m0_r_ready(f_r_ready), .m0_r_data(f_r_data), .m0_r_resp(),
    .m1_ar_valid(l_ar_valid), .m1_ar_ready(l_ar_ready), .m1_ar_addr(l_ar_addr),
    .m1_r_valid(l_r_valid), .m1_r_ready(l_r_ready), .m1_r_data(l_r_data),
    .m1_r_resp(l_r_resp),
    .s_ar_valid, .s_ar_ready, .s_ar_addr, .s_r_valid, .s_r_ready, .s_r_data, .s_r_resp
  );

  axi_sram #(.mem_words(mem_words)) u_sram (
    .clk, .rst,
    .ar_valid(s_ar_valid), .ar_ready(s_ar_ready), .ar_addr(s_ar_addr),
    .r_valid(s_r_valid), .r_ready(s_r_ready), .r_data(s_r_data), .r_resp(s_r_resp),
    .aw_valid, .aw_ready, .aw_addr, .w_valid, .w_ready, .w_data, .w_strb,
    .b_valid, .b_ready, .b_resp
  );

endmodule

// ==== source/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram #(
  parameter int mem_words = mem_pkg::mem_words_def
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ar_valid,
  output logic                       ar_ready,
  input  logic [mem_pkg::addr_w-1:0] ar_addr,
  output logic                       r_valid,
  input  logic                       r_ready,
  output logic [mem_pkg::bus_w-1:0]  r_data,
  output mem_pkg::resp_e             r_resp,
  input  logic                       aw_valid,
  output logic                       aw_ready,
  input  logic [mem_pkg::addr_w-1:0] aw_addr,
  input  logic                       w_valid,
  output logic                       w_ready,
  input  logic [mem_pkg::bus_w-1:0]  w_data,
  input  logic [mem_pkg::strb_w-1:0] w_strb,
  output logic                       b_valid,
  input  logic                       b_ready,
  output mem_pkg::resp_e             b_resp
);
  import mem_pkg::*;

  // depth is a power of two, upper address bits alias
  localparam int idx_w = $clog2(mem_words);

  logic [bus_w-1:0]  mem [mem_words];
  logic              have_aw;
  logic              have_w;
  logic [addr_w-1:0] aw_addr_q;
  logic [bus_w-1:0]  w_data_q;
  logic [strb_w-1:0] w_strb_q;
  logic              aw_done;
  logic              w_done;
  logic [addr_w-1:0] wr_addr;
  logic [bus_w-1:0]  wr_data;
  logic [strb_w-1:0] wr_strb;

  assign ar_ready = !r_valid;
  assign aw_ready = !have_aw && !b_valid;
  assign w_ready  = !have_w && !b_valid;
  assign r_resp   = resp_okay;
  assign b_resp   = resp_okay;

  // address and data may arrive in either order
  assign aw_done = have_aw || (aw_valid && aw_ready);
  assign w_done  = have_w || (w_valid && w_ready);
  assign wr_addr = have_aw ? aw_addr_q : aw_addr;
  assign wr_data = have_w ? w_data_q : w_data;
  assign wr_strb = have_w ? w_strb_q : w_strb;

  always_ff @(posedge clk) begin
    if (rst) begin
      have_aw <= 1'b0;
      have_w  <= 1'b0;
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
      if (aw_done && w_done) begin
        b_valid <= 1'b1;
        have_aw <= 1'b0;
        have_w  <= 1'b0;
      end else begin
        if (aw_valid && aw_ready) have_aw <= 1'b1;
        if (w_valid && w_ready) have_w <= 1'b1;
      end
      if (ar_valid && ar_ready) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) aw_addr_q <= aw_addr;
    if (w_valid && w_ready) begin
      w_data_q <= w_data;
      w_strb_q <= w_strb;
    end
    // commit on the edge that raises b_valid
    if (aw_done && w_done) begin
      for (int i = 0; i < strb_w; i++) begin
        if (wr_strb[i]) mem[wr_addr[3 +: idx_w]][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
    if (ar_valid && ar_ready) begin
      r_data <= mem[ar_addr[3 +: idx_w]];
    end
  end

  a_b_after_write: assert property (@(posedge clk) disable iff (rst)
    $rose(b_valid) |-> $past(aw_done && w_done));

endmodule

// ==== source/axi_read_arbiter.sv ====
`timescale 1ns/1ps

module axi_read_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       m0_ar_valid,
  output logic                       m0_ar_ready,
  input  logic [mem_pkg::addr_w-1:0] m0_ar_addr,
  output logic                       m0_r_valid,
  input  logic                       m0_r_ready,
  output logic [mem_pkg::bus_w-1:0]  m0_r_data,
  output mem_pkg::resp_e             m0_r_resp,
  input  logic                       m1_ar_valid,
  output logic                       m1_ar_ready,
  input  logic [mem_pkg::addr_w-1:0] m1_ar_addr,
  output logic                       m1_r_valid,
  input  logic                       m1_r_ready,
  output logic [mem_pkg::bus_w-1:0]  m1_r_data,
  output mem_pkg::resp_e             m1_r_resp,
  output logic                       s_ar_valid,
  input  logic                       s_ar_ready,
  output logic [mem_pkg::addr_w-1:0] s_ar_addr,
  input  logic                       s_r_valid,
  output logic                       s_r_ready,
  input  logic [mem_pkg::bus_w-1:0]  s_r_data,
  input  mem_pkg::resp_e             s_r_resp
);

  // transaction in flight with the grant locked
  logic busy;
  // last winner and the owner while busy
  logic gnt;
  logic sel;

  always_comb begin
    if (busy) begin
      sel = gnt;
    end else if (m0_ar_valid && m1_ar_valid) begin
      // tie goes to the master that lost last time
      sel = !gnt;
    end else begin
      sel = m1_ar_valid;
    end
  end

  assign s_ar_valid  = !busy && (sel ? m1_ar_valid : m0_ar_valid);
  assign s_ar_addr   = sel ? m1_ar_addr : m0_ar_addr;
  assign m0_ar_ready = !busy && !sel && s_ar_ready;
  assign m1_ar_ready = !busy && sel && s_ar_ready;

  // read data valid only toward the owner
  assign m0_r_valid = busy && !gnt && s_r_valid;
  assign m1_r_valid = busy && gnt && s_r_valid;
  assign s_r_ready  = busy && (gnt ? m1_r_ready : m0_r_ready);
  assign m0_r_data  = s_r_data;
  assign m1_r_data  = s_r_data;
  assign m0_r_resp  = s_r_resp;
  assign m1_r_resp  = s_r_resp;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      // m0 wins the first tie
      gnt  <= 1'b1;
    end else if (!busy && s_ar_valid && s_ar_ready) begin
      busy <= 1'b1;
      gnt  <= sel;
    end else if (busy && s_r_valid && s_r_ready) begin
      busy <= 1'b0;
    end
  end

  // slave read data only ever answers the one locked owner
  a_one_owner: assert property (@(posedge clk) disable iff (rst)
    s_r_valid |-> busy);

endmodule

// ==== source/ifetch.sv ====
`timescale 1ns/1ps

module ifetch (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_req,
  input  logic [mem_pkg::addr_w-1:0] fetch_pc,
  output logic [mem_pkg::data_w-1:0] inst,
  output logic                       inst_valid,
  output logic                       ar_valid,
  input  logic                       ar_ready,
  output logic [mem_pkg::addr_w-1:0] ar_addr,
  input  logic                       r_valid,
  output logic                       r_ready,
  input  logic [mem_pkg::bus_w-1:0]  r_data
);
  import mem_pkg::*;

  xfer_state_e state;
  // upper word of the beat
  logic        hi_sel;

  assign r_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      ar_valid   <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (fetch_req) begin
            ar_valid <= 1'b1;
            ar_addr  <= {fetch_pc[addr_w-1:3], 3'b000};
            hi_sel   <= fetch_pc[2];
            state    <= st_tran1;
          end
        end
        default: begin
          if (ar_valid && ar_ready) begin
            ar_valid <= 1'b0;
          end
          if (r_valid && r_ready) begin
            inst       <= hi_sel ? r_data[bus_w-1:data_w] : r_data[data_w-1:0];
            inst_valid <= 1'b1;
            state      <= st_idle;
          end
        end
      endcase
    end
  end

  // core waits for inst_valid before the next request
  a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
    fetch_req |-> state == st_idle);

endmodule

// ==== source/lsu.sv ====
`timescale 1ns/1ps

module lsu #(
  parameter logic [mem_pkg::addr_w-1:0] sram_base = mem_pkg::sram_base_def,
  parameter logic [mem_pkg::addr_w-1:0] sram_size = mem_pkg::sram_size_def
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inst_rvalid,
  input  logic                         ren,
  input  logic                         wen,
  input  logic [mem_pkg::addr_w-1:0]   raddr,
  input  logic [mem_pkg::addr_w-1:0]   waddr,
  input  logic [mem_pkg::data_w-1:0]   wdata,
  input  logic [7:0]                   wmask,
  input  mem_pkg::load_op_e            load_ctl,
  output logic [mem_pkg::data_w-1:0]   rdata,
  output logic                         lsu_finish,
  output logic                         ar_valid,
  input  logic                         ar_ready,
  output logic [mem_pkg::addr_w-1:0]   ar_addr,
  input  logic                         r_valid,
  output logic                         r_ready,
  input  logic [mem_pkg::bus_w-1:0]    r_data,
  input  mem_pkg::resp_e               r_resp,
  output logic                         aw_valid,
  input  logic                         aw_ready,
  output logic [mem_pkg::addr_w-1:0]   aw_addr,
  output logic                         w_valid,
  input  logic                         w_ready,
  output logic [mem_pkg::bus_w-1:0]    w_data,
  output logic [mem_pkg::strb_w-1:0]   w_strb,
  input  logic                         b_valid,
  output logic                         b_ready,
  input  mem_pkg::resp_e               b_resp
);
  import mem_pkg::*;

  xfer_state_e         rd_state;
  xfer_state_e         wr_state;
  logic                rd_sram;
  logic                wr_sram;
  logic [3:0]          rd_bytes;
  logic                rd_split;
  logic [bus_w-1:0]    rbeat0;
  logic [2*bus_w-1:0]  rd_pair;
  logic [2*bus_w-1:0]  rd_shift;
  logic [data_w-1:0]   rd_field;
  logic [data_w-1:0]   rd_ext;
  logic [2*strb_w-1:0] wr_mask_ext;
  logic                wr_split;
  logic [bus_w-1:0]    wr_word;
  logic [2*bus_w-1:0]  wr_rot;

  assign rd_sram = (raddr >= sram_base) && (raddr < sram_base + sram_size);
  assign wr_sram = (waddr >= sram_base) && (waddr < sram_base + sram_size);

  // responses always accepted
  assign r_ready = 1'b1;
  assign b_ready = 1'b1;

  // access width in bytes
  always_comb begin
    case (load_ctl)
      lb, lbu: rd_bytes = 4'd1;
      lh, lhu: rd_bytes = 4'd2;
      default: rd_bytes = 4'd4;
    endcase
  end

  // second beat when the field runs past lane 7
  assign rd_split = rd_sram && (({1'b0, raddr[2:0]} + rd_bytes) > 4'd8);

  // low beat comes first on a split load
  assign rd_pair  = rd_split ? {r_data, rbeat0} : {{bus_w{1'b0}}, r_data};
  assign rd_shift = rd_pair >> {raddr[2:0], 3'b000};
  assign rd_field = rd_sram ? rd_shift[data_w-1:0] : r_data[data_w-1:0];

  always_comb begin
    case (load_ctl)
      lb:      rd_ext = {{24{rd_field[7]}}, rd_field[7:0]};
      lh:      rd_ext = {{16{rd_field[15]}}, rd_field[15:0]};
      lbu:     rd_ext = {24'b0, rd_field[7:0]};
      lhu:     rd_ext = {16'b0, rd_field[15:0]};
      default: rd_ext = rd_field;
    endcase
  end

  // store lanes, upper byte of the mask spills into the next beat
  assign wr_mask_ext = {{strb_w{1'b0}}, wmask} << waddr[2:0];
  assign wr_split    = wr_sram && (wr_mask_ext[2*strb_w-1:strb_w] != '0);
  assign wr_word     = {{(bus_w-data_w){1'b0}}, wdata};
  // rotation leaves spilled bytes in the low lanes for beat two
  assign wr_rot      = {wr_word, wr_word} << {waddr[2:0], 3'b000};
  assign w_data      = wr_sram ? wr_rot[2*bus_w-1:bus_w] : wr_word;

  // load FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      ar_valid <= 1'b0;
      rd_state <= st_idle;
    end else begin
      case (rd_state)
        st_idle: begin
          if (inst_rvalid && ren) begin
            ar_valid <= 1'b1;
            ar_addr  <= {raddr[addr_w-1:3], 3'b000};
            rd_state <= rd_split ? st_tran2 : st_tran1;
          end
        end
        st_tran1, st_tran2: begin
          if (ar_valid && ar_ready) begin
            ar_valid <= 1'b0;
          end
          if (r_valid && r_ready) begin
            rd_state <= (rd_state == st_tran2) ? st_mid : st_idle;
          end
        end
        st_mid: begin
          ar_addr  <= ar_addr + 8;
          ar_valid <= 1'b1;
          rd_state <= st_tran1;
        end
      endcase
    end
  end

  // load data capture
  always_ff @(posedge clk) begin
    if (rd_state == st_tran2 && r_valid && r_ready) begin
      rbeat0 <= r_data;
    end
    if (rd_state == st_tran1 && r_valid && r_ready) begin
      rdata <= rd_ext;
    end
  end

  // store FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      wr_state <= st_idle;
    end else begin
      case (wr_state)
        st_idle: begin
          if (inst_rvalid && wen) begin
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
            aw_addr  <= {waddr[addr_w-1:3], 3'b000};
            // device writes keep the mask in the low lanes
            w_strb   <= wr_sram ? wr_mask_ext[strb_w-1:0] : wmask;
            wr_state <= wr_split ? st_tran2 : st_tran1;
          end
        end
        st_tran1, st_tran2: begin
          if (aw_valid && aw_ready) begin
            aw_valid <= 1'b0;
          end
          if (w_valid && w_ready) begin
            w_valid <= 1'b0;
          end
          if (b_valid && b_ready) begin
            wr_state <= (wr_state == st_tran2) ? st_mid : st_idle;
          end
        end
        st_mid: begin
          aw_addr  <= aw_addr + 8;
          aw_valid <= 1'b1;
          w_valid  <= 1'b1;
          w_strb   <= wr_mask_ext[2*strb_w-1:strb_w];
          wr_state <= st_tran1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lsu_finish <= 1'b0;
    end else begin
      lsu_finish <= (inst_rvalid && !ren && !wen)
                 || (wr_state == st_tran1 && b_valid && b_ready)
                 || (rd_state == st_tran1 && r_valid && r_ready);
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_valid && !ar_ready |=> ar_valid);

  // the memory never reports an error
  a_resp_okay: assert property (@(posedge clk) disable iff (rst)
    (r_valid -> r_resp == resp_okay) && (b_valid -> b_resp == resp_okay));

endmodule

// ==== source/mem_pkg.sv ====
package mem_pkg;

  // bus and core widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int bus_w  = 64;
  localparam int strb_w = bus_w / 8;

  // default memory map
  localparam logic [addr_w-1:0] sram_base_def = 32'h0f00_0000;
  localparam logic [addr_w-1:0] sram_size_def = 32'h0000_2000;
  localparam int mem_words_def = 1024;

  // load type, any unlisted code behaves as lw
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_op_e;

  // bus master transfer states
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_tran1 = 2'b01,
    st_tran2 = 2'b10,
    st_mid   = 2'b11
  } xfer_state_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

endpackage
